//--- rtl/rob_cfg_pkg.sv
// Configuration package for the re-order buffer
// Datapath widths, their vector types and the default buffer sizes
package rob_cfg_pkg;

    // Register data and instruction address widths
    localparam int DATA_WIDTH    = 32;
    localparam int ADDR_WIDTH    = 32;
    localparam int REG_IDX_WIDTH = 5;

    // Sizes the top level uses unless it is told otherwise
    localparam int DEF_ROB_DEPTH = 8;
    localparam int DEF_CDB_LANES = 2;

    typedef logic [DATA_WIDTH-1:0]    data_t;
    typedef logic [ADDR_WIDTH-1:0]    addr_t;
    typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;

endpackage

//--- rtl/rob_op_pkg.sv
// Operation and entry state encodings for the re-order buffer
package rob_op_pkg;

    // OP_BR redirects to the address from the CDB, OP_EXC to its own pc
    typedef enum logic [1:0] {
        OP_INT = 2'd0,
        OP_BR  = 2'd1,
        OP_EXC = 2'd2
    } rob_op_e;

    typedef enum logic [1:0] {
        ST_INVALID   = 2'd0,
        ST_PENDING   = 2'd1,
        ST_RETIRABLE = 2'd2
    } rob_state_e;

endpackage

//--- rtl/rob_cdb_if.sv
// Common data bus as seen by the re-order buffer
// Lanes arrive already arbitrated and each carries a one-cycle completion strobe
interface rob_cdb_if
    import rob_cfg_pkg::*;
#(
    parameter int ROB_DEPTH = DEF_ROB_DEPTH,
    parameter int CDB_LANES = DEF_CDB_LANES
) ();

    localparam int TAG_WIDTH = $clog2(ROB_DEPTH);

    logic                 en       [CDB_LANES];
    logic                 redirect [CDB_LANES];
    data_t                data     [CDB_LANES];
    addr_t                addr     [CDB_LANES];
    logic [TAG_WIDTH-1:0] tag      [CDB_LANES];

    // Completion writes into the entry store
    modport store (input en, redirect, data, addr, tag);

    // Same-cycle forwarding into the operand lookup
    modport bypass (input en, data, tag);

endinterface

//--- rtl/rob_head_if.sv
// Head entry view of the re-order buffer
// The pointers give the index, the entry store gives the fields held there
interface rob_head_if
    import rob_cfg_pkg::*;
    import rob_op_pkg::*;
#(
    parameter int ROB_DEPTH = DEF_ROB_DEPTH
) ();

    localparam int TAG_WIDTH = $clog2(ROB_DEPTH);

    logic [TAG_WIDTH-1:0] head;
    logic                 retire_en;
    logic                 redirect;
    rob_op_e              op;
    addr_t                pc;
    addr_t                addr;
    data_t                data;
    reg_idx_t             rdest;

    modport pointer (output head, input retire_en);

    modport entry (input head, output retire_en, redirect, op, pc, addr, data, rdest);

    modport retire (input head, retire_en, redirect, op, pc, addr, data, rdest);

endinterface

//--- rtl/rob_pointers.sv
// Head and tail pointers of the re-order buffer
// Hands out rename tags, tracks full and selects the entry for the next enqueue
module rob_pointers
    import rob_cfg_pkg::*;
#(
    parameter int  ROB_DEPTH = DEF_ROB_DEPTH,
    localparam int TAG_WIDTH = $clog2(ROB_DEPTH)
) (
    input  logic                 clk,
    input  logic                 n_rst,
    input  logic                 i_rename_en,
    input  logic                 i_redirect,
    output logic                 o_stall,
    output logic [TAG_WIDTH-1:0] o_rename_tag,
    output logic [ROB_DEPTH-1:0] o_dispatch_sel,
    rob_head_if.pointer          head
);

    // The extra wrap bit tells a full buffer apart from an empty one
    logic [TAG_WIDTH:0] head_r;
    logic [TAG_WIDTH:0] tail_r;
    logic [TAG_WIDTH:0] head_next;
    logic [TAG_WIDTH:0] tail_next;
    logic               full_r;
    logic               rename_ok;

    // Renames in the redirect cycle belong to the squashed path
    assign rename_ok = i_rename_en && !full_r && !i_redirect;

    assign tail_next = i_redirect ? '0 : tail_r + (TAG_WIDTH + 1)'(rename_ok);
    assign head_next = i_redirect ? '0 : head_r + (TAG_WIDTH + 1)'(head.retire_en);

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            head_r <= '0;
            tail_r <= '0;
            full_r <= 1'b0;
        end else begin
            head_r <= head_next;
            tail_r <= tail_next;
            full_r <= {~tail_next[TAG_WIDTH], tail_next[TAG_WIDTH-1:0]} == head_next;
        end
    end

    // The dispatcher fills the reserved entry one cycle after the rename
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_dispatch_sel <= '0;
        end else begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                o_dispatch_sel[i] <= rename_ok && (tail_r[TAG_WIDTH-1:0] == TAG_WIDTH'(i));
            end
        end
    end

    assign o_stall      = full_r;
    assign o_rename_tag = tail_r[TAG_WIDTH-1:0];
    assign head.head    = head_r[TAG_WIDTH-1:0];

    // The head never passes the tail and the tail never runs more than a whole buffer ahead
    occupancy_in_range: assert property (
        @(posedge clk) disable iff (!n_rst)
        (TAG_WIDTH + 1)'(tail_r - head_r) <= ROB_DEPTH
    );

endmodule

//--- rtl/rob_entries.sv
// Entry store of the re-order buffer
// Holds each in-flight instruction and moves it through invalid, pending and retirable
module rob_entries
    import rob_cfg_pkg::*;
    import rob_op_pkg::*;
#(
    parameter int  ROB_DEPTH = DEF_ROB_DEPTH,
    parameter int  CDB_LANES = DEF_CDB_LANES,
    localparam int TAG_WIDTH = $clog2(ROB_DEPTH)
) (
    input  logic                 clk,
    input  logic                 n_rst,
    input  logic                 i_enq_en,
    input  rob_op_e              i_enq_op,
    input  addr_t                i_enq_pc,
    input  reg_idx_t             i_enq_rdest,
    input  logic [ROB_DEPTH-1:0] i_dispatch_sel,
    input  logic                 i_flush,
    rob_cdb_if.store             cdb,
    rob_head_if.entry            head,
    output rob_state_e           o_state [ROB_DEPTH],
    output data_t                o_data  [ROB_DEPTH]
);

    rob_op_e    op_r         [ROB_DEPTH];
    addr_t      pc_r         [ROB_DEPTH];
    reg_idx_t   rdest_r      [ROB_DEPTH];
    addr_t      addr_r       [ROB_DEPTH];
    data_t      data_r       [ROB_DEPTH];
    logic       redirect_r   [ROB_DEPTH];
    rob_state_e state_r      [ROB_DEPTH];
    rob_state_e state_next   [ROB_DEPTH];

    logic       enq_hit      [ROB_DEPTH];
    logic       cdb_hit      [ROB_DEPTH];
    logic       cdb_redirect [ROB_DEPTH];
    data_t      cdb_data     [ROB_DEPTH];
    addr_t      cdb_addr     [ROB_DEPTH];

    // Lanes never share a tag in one cycle, so at most one lane matches an entry
    always_comb begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            enq_hit[i]      = i_enq_en && i_dispatch_sel[i];
            cdb_hit[i]      = 1'b0;
            cdb_redirect[i] = 1'b0;
            cdb_data[i]     = '0;
            cdb_addr[i]     = '0;
            for (int l = 0; l < CDB_LANES; l++) begin
                if (cdb.en[l] && cdb.tag[l] == TAG_WIDTH'(i)) begin
                    cdb_hit[i]      = 1'b1;
                    cdb_redirect[i] = cdb.redirect[l];
                    cdb_data[i]     = cdb.data[l];
                    cdb_addr[i]     = cdb.addr[l];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            // A fresh entry starts without a pending redirect
            if (enq_hit[i]) begin
                op_r[i]       <= i_enq_op;
                pc_r[i]       <= i_enq_pc;
                rdest_r[i]    <= i_enq_rdest;
                redirect_r[i] <= 1'b0;
            end else if (cdb_hit[i]) begin
                redirect_r[i] <= cdb_redirect[i];
            end
            if (cdb_hit[i]) begin
                data_r[i] <= cdb_data[i];
                addr_r[i] <= cdb_addr[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            case (state_r[i])
                ST_INVALID:   state_next[i] = enq_hit[i] ? ST_PENDING : ST_INVALID;
                ST_PENDING:   state_next[i] = cdb_hit[i] ? ST_RETIRABLE : ST_PENDING;
                ST_RETIRABLE: state_next[i] = (head.retire_en && head.head == TAG_WIDTH'(i)) ?
                                              ST_INVALID : ST_RETIRABLE;
                default:      state_next[i] = ST_INVALID;
            endcase
        end
    end

    // A redirecting retire drops the whole buffer at the same edge
    always_ff @(posedge clk) begin
        for (int i = 0; i < ROB_DEPTH; i++) begin
            if (!n_rst) begin
                state_r[i] <= ST_INVALID;
            end else if (i_flush) begin
                state_r[i] <= ST_INVALID;
            end else begin
                state_r[i] <= state_next[i];
            end
        end
    end

    assign head.retire_en = state_r[head.head] == ST_RETIRABLE;
    assign head.redirect  = redirect_r[head.head];
    assign head.op        = op_r[head.head];
    assign head.pc        = pc_r[head.head];
    assign head.addr      = addr_r[head.head];
    assign head.data      = data_r[head.head];
    assign head.rdest     = rdest_r[head.head];

    assign o_state = state_r;
    assign o_data  = data_r;

    // Execution units only broadcast tags that the dispatcher has filled
    for (genvar l = 0; l < CDB_LANES; l++) begin : g_cdb_chk
        cdb_hits_live_entry: assert property (
            @(posedge clk) disable iff (!n_rst)
            cdb.en[l] |-> state_r[cdb.tag[l]] != ST_INVALID
        );
    end

endmodule

//--- rtl/rob_retire.sv
// Retire stage of the re-order buffer
// Registers the head entry for the register map and raises a redirect when it asks for one
module rob_retire
    import rob_cfg_pkg::*;
    import rob_op_pkg::*;
#(
    parameter int  ROB_DEPTH = DEF_ROB_DEPTH,
    localparam int TAG_WIDTH = $clog2(ROB_DEPTH)
) (
    input  logic                 clk,
    input  logic                 n_rst,
    rob_head_if.retire           head,
    output logic                 o_flush,
    output logic                 o_redirect,
    output addr_t                o_redirect_addr,
    output logic                 o_retire_en,
    output data_t                o_retire_data,
    output reg_idx_t             o_retire_rdest,
    output logic [TAG_WIDTH-1:0] o_retire_tag
);

    // Younger entries are dropped at the edge that retires the redirecting head
    assign o_flush = head.retire_en && head.redirect;

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_retire_en <= 1'b0;
            o_redirect  <= 1'b0;
        end else begin
            o_retire_en <= head.retire_en;
            o_redirect  <= o_flush;
        end
    end

    // Branches jump to the target from execution, faults restart at their own pc
    always_ff @(posedge clk) begin
        o_retire_data   <= head.data;
        o_retire_rdest  <= head.rdest;
        o_retire_tag    <= head.head;
        o_redirect_addr <= (head.op == OP_BR) ? head.addr : head.pc;
    end

    // The redirect rides on its own retire, and the flush leaves nothing behind it
    redirect_with_retire: assert property (
        @(posedge clk) disable iff (!n_rst)
        o_redirect |-> o_retire_en ##1 !o_retire_en
    );

endmodule

//--- rtl/rob_operand_lookup.sv
// Source operand lookup for the reservation stations
// Picks register-map data, a same-cycle CDB value or stored entry data per source
module rob_operand_lookup
    import rob_cfg_pkg::*;
    import rob_op_pkg::*;
#(
    parameter int  ROB_DEPTH = DEF_ROB_DEPTH,
    parameter int  CDB_LANES = DEF_CDB_LANES,
    localparam int TAG_WIDTH = $clog2(ROB_DEPTH)
) (
    input  logic                 clk,
    input  logic                 i_rs_stall,
    input  logic [TAG_WIDTH-1:0] i_lookup_tag  [2],
    input  logic                 i_lookup_rdy  [2],
    input  data_t                i_lookup_data [2],
    input  rob_state_e           i_state       [ROB_DEPTH],
    input  data_t                i_data        [ROB_DEPTH],
    rob_cdb_if.bypass            cdb,
    output data_t                o_src_data    [2],
    output logic [TAG_WIDTH-1:0] o_src_tag     [2],
    output logic                 o_src_rdy     [2]
);

    data_t src_data [2];
    logic  src_rdy  [2];

    // Priority rises from the entry store over the CDB bypass to the register map
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            src_data[s] = i_data[i_lookup_tag[s]];
            src_rdy[s]  = i_state[i_lookup_tag[s]] == ST_RETIRABLE;
            for (int l = 0; l < CDB_LANES; l++) begin
                if (cdb.en[l] && cdb.tag[l] == i_lookup_tag[s]) begin
                    src_data[s] = cdb.data[l];
                    src_rdy[s]  = 1'b1;
                end
            end
            if (i_lookup_rdy[s]) begin
                src_data[s] = i_lookup_data[s];
                src_rdy[s]  = 1'b1;
            end
        end
    end

    // A stalled reservation station keeps the operands it was last given
    always_ff @(posedge clk) begin
        if (!i_rs_stall) begin
            o_src_data <= src_data;
            o_src_tag  <= i_lookup_tag;
            o_src_rdy  <= src_rdy;
        end
    end

endmodule

//--- rtl/rob_top.sv
// Re-order buffer top level
// Renames, collects CDB completions and retires in program order with redirect
module rob_top
    import rob_cfg_pkg::*;
    import rob_op_pkg::*;
#(
    parameter int  ROB_DEPTH = DEF_ROB_DEPTH,
    parameter int  CDB_LANES = DEF_CDB_LANES,
    localparam int TAG_WIDTH = $clog2(ROB_DEPTH)
) (
    input  logic                 clk,
    input  logic                 n_rst,

    // Rename and enqueue from the dispatcher
    input  logic                 i_rename_en,
    output logic [TAG_WIDTH-1:0] o_rename_tag,
    output logic                 o_stall,
    input  logic                 i_enq_en,
    input  rob_op_e              i_enq_op,
    input  addr_t                i_enq_pc,
    input  reg_idx_t             i_enq_rdest,

    input  logic                 i_cdb_en       [CDB_LANES],
    input  logic                 i_cdb_redirect [CDB_LANES],
    input  data_t                i_cdb_data     [CDB_LANES],
    input  addr_t                i_cdb_addr     [CDB_LANES],
    input  logic [TAG_WIDTH-1:0] i_cdb_tag      [CDB_LANES],

    // Operand lookup for the reservation stations
    input  logic                 i_rs_stall,
    input  logic [TAG_WIDTH-1:0] i_lookup_tag   [2],
    input  logic                 i_lookup_rdy   [2],
    input  data_t                i_lookup_data  [2],
    output data_t                o_src_data     [2],
    output logic [TAG_WIDTH-1:0] o_src_tag      [2],
    output logic                 o_src_rdy      [2],

    // Retire to the register map and redirect to fetch
    output logic                 o_retire_en,
    output data_t                o_retire_data,
    output reg_idx_t             o_retire_rdest,
    output logic [TAG_WIDTH-1:0] o_retire_tag,
    output logic                 o_redirect,
    output addr_t                o_redirect_addr
);

    logic                 flush;
    logic [ROB_DEPTH-1:0] dispatch_sel;
    rob_state_e           entry_state [ROB_DEPTH];
    data_t                entry_data  [ROB_DEPTH];

    rob_cdb_if #(.ROB_DEPTH(ROB_DEPTH), .CDB_LANES(CDB_LANES)) cdb ();
    rob_head_if #(.ROB_DEPTH(ROB_DEPTH)) head ();

    assign cdb.en       = i_cdb_en;
    assign cdb.redirect = i_cdb_redirect;
    assign cdb.data     = i_cdb_data;
    assign cdb.addr     = i_cdb_addr;
    assign cdb.tag      = i_cdb_tag;

    rob_pointers #(.ROB_DEPTH(ROB_DEPTH)) u_pointers (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_rename_en    (i_rename_en),
        .i_redirect     (o_redirect),
        .o_stall        (o_stall),
        .o_rename_tag   (o_rename_tag),
        .o_dispatch_sel (dispatch_sel),
        .head           (head)
    );

    rob_entries #(.ROB_DEPTH(ROB_DEPTH), .CDB_LANES(CDB_LANES)) u_entries (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_enq_en       (i_enq_en),
        .i_enq_op       (i_enq_op),
        .i_enq_pc       (i_enq_pc),
        .i_enq_rdest    (i_enq_rdest),
        .i_dispatch_sel (dispatch_sel),
        .i_flush        (flush),
        .cdb            (cdb),
        .head           (head),
        .o_state        (entry_state),
        .o_data         (entry_data)
    );

    rob_retire #(.ROB_DEPTH(ROB_DEPTH)) u_retire (
        .clk             (clk),
        .n_rst           (n_rst),
        .head            (head),
        .o_flush         (flush),
        .o_redirect      (o_redirect),
        .o_redirect_addr (o_redirect_addr),
        .o_retire_en     (o_retire_en),
        .o_retire_data   (o_retire_data),
        .o_retire_rdest  (o_retire_rdest),
        .o_retire_tag    (o_retire_tag)
    );

    rob_operand_lookup #(.ROB_DEPTH(ROB_DEPTH), .CDB_LANES(CDB_LANES)) u_lookup (
        .clk           (clk),
        .i_rs_stall    (i_rs_stall),
        .i_lookup_tag  (i_lookup_tag),
        .i_lookup_rdy  (i_lookup_rdy),
        .i_lookup_data (i_lookup_data),
        .i_state       (entry_state),
        .i_data        (entry_data),
        .cdb           (cdb),
        .o_src_data    (o_src_data),
        .o_src_tag     (o_src_tag),
        .o_src_rdy     (o_src_rdy)
    );

endmodule

//--- test/tb_rob.sv
// Testbench for the re-order buffer
// Replays instruction vectors and checks retire order, redirect, stall and operand lookup
module tb_rob
    import rob_cfg_pkg::*;
    import rob_op_pkg::*;
();

    localparam int ROB_DEPTH      = DEF_ROB_DEPTH;
    localparam int CDB_LANES      = DEF_CDB_LANES;
    localparam int TAG_W          = $clog2(ROB_DEPTH);
    localparam int N_VEC          = 22;
    localparam int N_COL          = 12;
    localparam int TIMEOUT_CYCLES = 20 * N_VEC + 200;

    // Columns of one vector line, in file order
    typedef enum int {
        C_GRP, C_OP, C_PC, C_RDEST, C_SLOT, C_DATA,
        C_ADDR, C_REDIR, C_LK_MODE, C_LK_DATA, C_EXP_RDY, C_EXP_DATA
    } col_e;

    typedef enum int {LK_NONE, LK_REGMAP, LK_BYPASS, LK_STORED, LK_PENDING} lk_mode_e;

    typedef struct packed {
        reg_idx_t         rdest;
        data_t            data;
        logic [TAG_W-1:0] tag;
        logic             redirect;
        addr_t            raddr;
    } retire_t;

    logic             clk;
    logic             n_rst;
    logic             i_rename_en;
    logic [TAG_W-1:0] o_rename_tag;
    logic             o_stall;
    logic             i_enq_en;
    rob_op_e          i_enq_op;
    addr_t            i_enq_pc;
    reg_idx_t         i_enq_rdest;
    logic             i_cdb_en       [CDB_LANES];
    logic             i_cdb_redirect [CDB_LANES];
    data_t            i_cdb_data     [CDB_LANES];
    addr_t            i_cdb_addr     [CDB_LANES];
    logic [TAG_W-1:0] i_cdb_tag      [CDB_LANES];
    logic             i_rs_stall;
    logic [TAG_W-1:0] i_lookup_tag   [2];
    logic             i_lookup_rdy   [2];
    data_t            i_lookup_data  [2];
    data_t            o_src_data     [2];
    logic [TAG_W-1:0] o_src_tag      [2];
    logic             o_src_rdy      [2];
    logic             o_retire_en;
    data_t            o_retire_data;
    reg_idx_t         o_retire_rdest;
    logic [TAG_W-1:0] o_retire_tag;
    logic             o_redirect;
    addr_t            o_redirect_addr;

    logic [31:0]      vec_mem [N_VEC * N_COL];
    logic [TAG_W-1:0] vec_tag [N_VEC];
    logic [TAG_W-1:0] exp_tag;
    retire_t          exp_q [$];
    int               n_checks;
    int               n_errors;
    int               cycles;

    rob_top uut (.*);

    always #50 clk = ~clk;

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [31:0] vec_field(input int idx, input col_e col);
        return vec_mem[idx * N_COL + int'(col)];
    endfunction

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] want);
        n_checks++;
        assert (got === want) else begin
            n_errors++;
            $display("Error at %0t: %s is %0h, expected %0h", $time, what, got, want);
        end
    endtask

    task automatic clear_cdb();
        for (int l = 0; l < CDB_LANES; l++) begin
            i_cdb_en[l]       = 1'b0;
            i_cdb_redirect[l] = 1'b0;
            i_cdb_data[l]     = '0;
            i_cdb_addr[l]     = '0;
            i_cdb_tag[l]      = '0;
        end
    endtask

    task automatic drive_cdb(input int idx);
        int lane;
        lane = $urandom % CDB_LANES;
        for (int l = 0; l < CDB_LANES; l++) begin
            i_cdb_en[l] = (l == lane);
        end
        i_cdb_tag[lane]      = vec_tag[idx];
        i_cdb_data[lane]     = vec_field(idx, C_DATA);
        i_cdb_addr[lane]     = vec_field(idx, C_ADDR);
        i_cdb_redirect[lane] = vec_field(idx, C_REDIR) != 0;
    endtask

    // Even vectors query source 0 and odd ones source 1, then a stalled cycle must hold them
    task automatic query_operand(input int idx);
        int               s;
        logic [TAG_W-1:0] tag;
        logic             exp_rdy;
        data_t            exp_data;
        s        = idx % 2;
        tag      = vec_tag[idx];
        exp_rdy  = vec_field(idx, C_EXP_RDY) != 0;
        exp_data = vec_field(idx, C_EXP_DATA);
        i_lookup_tag[s]  = tag;
        i_lookup_rdy[s]  = vec_field(idx, C_LK_MODE) == LK_REGMAP;
        i_lookup_data[s] = vec_field(idx, C_LK_DATA);
        next_cycle();
        clear_cdb();
        for (int hold = 0; hold < 2; hold++) begin
            compare_value(hold ? "held lookup tag" : "lookup tag", o_src_tag[s], tag);
            compare_value(hold ? "held lookup ready" : "lookup ready", o_src_rdy[s], exp_rdy);
            if (exp_rdy) begin
                compare_value(hold ? "held lookup data" : "lookup data", o_src_data[s], exp_data);
            end
            if (hold == 0) begin
                i_rs_stall       = 1'b1;
                i_lookup_tag[s]  = tag + 1'b1;
                i_lookup_rdy[s]  = 1'b1;
                i_lookup_data[s] = ~exp_data;
                next_cycle();
            end
        end
        i_rs_stall       = 1'b0;
        i_lookup_tag[s]  = '0;
        i_lookup_rdy[s]  = 1'b0;
        i_lookup_data[s] = '0;
    endtask

    task automatic complete_entry(input int idx);
        int mode;
        mode = vec_field(idx, C_LK_MODE);
        if (mode == LK_PENDING) begin
            query_operand(idx);
        end
        drive_cdb(idx);
        if (mode == LK_REGMAP || mode == LK_BYPASS) begin
            query_operand(idx);
        end else begin
            next_cycle();
            clear_cdb();
        end
        if (mode == LK_STORED) begin
            query_operand(idx);
        end
    endtask

    // Each rename is followed by its enqueue one cycle later, overlapping the next rename
    task automatic rename_batch(input int first, input int last, output logic redirected);
        retire_t item;
        logic    full_batch;
        full_batch = (last - first + 1) == ROB_DEPTH;
        redirected = 1'b0;
        for (int i = first; i <= last + 1; i++) begin
            i_rename_en = (i <= last) || full_batch;
            i_enq_en    = (i > first);
            if (i > first) begin
                i_enq_op    = rob_op_e'(2'(vec_field(i - 1, C_OP)));
                i_enq_pc    = vec_field(i - 1, C_PC);
                i_enq_rdest = vec_field(i - 1, C_RDEST);
            end
            if (i <= last) begin
                compare_value("rename tag", o_rename_tag, exp_tag);
                vec_tag[i] = exp_tag;
                // Entries younger than a redirect are squashed and never retire
                if (!redirected) begin
                    item.rdest    = vec_field(i, C_RDEST);
                    item.data     = vec_field(i, C_DATA);
                    item.tag      = exp_tag;
                    item.redirect = vec_field(i, C_REDIR) != 0;
                    item.raddr    = (vec_field(i, C_OP) == OP_BR) ?
                                    vec_field(i, C_ADDR) : vec_field(i, C_PC);
                    exp_q.push_back(item);
                    redirected = item.redirect;
                end
                exp_tag = (exp_tag == ROB_DEPTH - 1) ? '0 : exp_tag + 1'b1;
            end
            next_cycle();
        end
        i_rename_en = 1'b0;
        i_enq_en    = 1'b0;
        compare_value("stall after renames", o_stall, full_batch);
        compare_value("tag after renames", o_rename_tag, exp_tag);
    endtask

    task automatic run_batch(input int first, input int last);
        logic redirected;
        rename_batch(first, last, redirected);
        for (int s = 0; s <= last - first; s++) begin
            for (int i = first; i <= last; i++) begin
                if (vec_field(i, C_SLOT) == s) begin
                    complete_entry(i);
                end
            end
        end
        while (exp_q.size() != 0) begin
            next_cycle();
        end
        repeat (4) next_cycle();
        if (redirected) begin
            exp_tag = '0;
        end
    endtask

    // Retire monitor compares each retire with the oldest predicted entry
    always @(negedge clk) begin
        retire_t item;
        if (n_rst && o_retire_en) begin
            assert (exp_q.size() != 0) else begin
                n_errors++;
                $display("Error at %0t: retire of tag %0d with no entry left to retire",
                         $time, o_retire_tag);
            end
            if (exp_q.size() != 0) begin
                item = exp_q.pop_front();
                compare_value("retire tag", o_retire_tag, item.tag);
                compare_value("retire rdest", o_retire_rdest, item.rdest);
                compare_value("retire data", o_retire_data, item.data);
                compare_value("redirect", o_redirect, item.redirect);
                compare_value("stall at retire", o_stall, 1'b0);
                if (item.redirect) begin
                    compare_value("redirect address", o_redirect_addr, item.raddr);
                end
            end
        end else if (n_rst) begin
            compare_value("redirect without retire", o_redirect, 1'b0);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        int first;
        int last;
        int seed_draw;
        clk         = 1'b0;
        n_rst       = 1'b0;
        i_rename_en = 1'b0;
        i_enq_en    = 1'b0;
        i_enq_op    = OP_INT;
        i_enq_pc    = '0;
        i_enq_rdest = '0;
        i_rs_stall  = 1'b0;
        clear_cdb();
        for (int s = 0; s < 2; s++) begin
            i_lookup_tag[s]  = '0;
            i_lookup_rdy[s]  = 1'b0;
            i_lookup_data[s] = '0;
        end
        n_checks  = 0;
        n_errors  = 0;
        cycles    = 0;
        exp_tag   = '0;
        seed_draw = $urandom(32'hb2d9);
        $readmemh("test/rob_vectors.txt", vec_mem);
        repeat (5) @(posedge clk);
        #1;
        n_rst = 1'b1;
        if ($isunknown(vec_mem[N_VEC * N_COL - 1])) begin
            n_errors++;
            $display("Vector file test/rob_vectors.txt is missing or has fewer than %0d lines",
                     N_VEC);
        end else begin
            compare_value("retire enable after reset", o_retire_en, 1'b0);
            compare_value("redirect after reset", o_redirect, 1'b0);
            compare_value("stall after reset", o_stall, 1'b0);
            compare_value("rename tag after reset", o_rename_tag, '0);
            first = 0;
            while (first < N_VEC) begin
                last = first;
                while (last + 1 < N_VEC &&
                       vec_field(last + 1, C_GRP) == vec_field(first, C_GRP)) begin
                    last++;
                end
                run_batch(first, last);
                first = last + 1;
            end
        end
        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- test/rob_vectors.txt
// grp op pc rdest slot cdb_data cdb_addr redir lk_mode lk_data exp_rdy exp_data
// lk_mode: 0 none, 1 register map, 2 CDB bypass, 3 completed entry, 4 pending entry
0 0 00001000 01 2 11110000 00000000 0 2 00000000 1 11110000
0 0 00001004 02 0 11110001 00000000 0 1 aaaa0001 1 aaaa0001
0 0 00001008 03 4 11110002 00000000 0 4 00000000 0 00000000
0 0 0000100c 04 1 11110003 00000000 0 3 00000000 1 11110003
0 0 00001010 05 3 11110004 00000000 0 0 00000000 0 00000000
1 0 00002000 06 3 22220000 00000000 0 3 00000000 1 22220000
1 0 00002004 07 7 22220001 00000000 0 0 00000000 0 00000000
1 0 00002008 08 0 22220002 00000000 0 4 00000000 0 00000000
1 0 0000200c 09 5 22220003 00000000 0 2 00000000 1 22220003
1 0 00002010 0a 1 22220004 00000000 0 1 bbbb0004 1 bbbb0004
1 0 00002014 0b 6 22220005 00000000 0 0 00000000 0 00000000
1 0 00002018 0c 2 22220006 00000000 0 3 00000000 1 22220006
1 0 0000201c 0d 4 22220007 00000000 0 4 00000000 0 00000000
2 0 00003000 0e 1 33330000 00000000 0 2 00000000 1 33330000
2 0 00003004 0f 0 33330001 00000000 0 4 00000000 0 00000000
2 1 00003008 10 4 33330002 00008000 1 3 00000000 1 33330002
2 0 0000300c 11 3 33330003 00000000 0 1 cccc0003 1 cccc0003
2 0 00003010 12 2 33330004 00000000 0 0 00000000 0 00000000
3 0 00004000 13 0 44440000 00000000 0 1 dddd0000 1 dddd0000
3 2 00004004 14 3 44440001 0000dead 1 3 00000000 1 44440001
3 0 00004008 15 2 44440002 00000000 0 2 00000000 1 44440002
3 0 0000400c 16 1 44440003 00000000 0 4 00000000 0 00000000

//--- verilog.f
rtl/rob_cfg_pkg.sv
rtl/rob_op_pkg.sv
rtl/rob_cdb_if.sv
rtl/rob_head_if.sv
rtl/rob_pointers.sv
rtl/rob_entries.sv
rtl/rob_retire.sv
rtl/rob_operand_lookup.sv
rtl/rob_top.sv
test/tb_rob.sv

//--- Bender.yml
package:
  name: rob

sources:
  - rtl/rob_cfg_pkg.sv
  - rtl/rob_op_pkg.sv
  - rtl/rob_cdb_if.sv
  - rtl/rob_head_if.sv
  - rtl/rob_pointers.sv
  - rtl/rob_entries.sv
  - rtl/rob_retire.sv
  - rtl/rob_operand_lookup.sv
  - rtl/rob_top.sv
  - target: test
    files:
      - test/tb_rob.sv
